/* source/shuffle_pkg.sv */
package shuffle_pkg;

  // register file sizes, physical count must be a power of two
  localparam int unsigned NUM_LOG_REGS  = 32;
  localparam int unsigned NUM_PHYS_REGS = 64;
  localparam int unsigned PHYS_IDX_W    = $clog2(NUM_PHYS_REGS); // 6 for 64 regs

  typedef logic [31:0]              addr_t;
  typedef logic [31:0]              instr_t;
  typedef logic [4:0]               log_reg_t;  // x0..x31
  typedef logic [PHYS_IDX_W-1:0]    phys_reg_t;
  typedef logic [NUM_PHYS_REGS-1:0] phys_vec_t; // one bit per physical reg

  // rv32i major opcodes, bits [6:0]
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011; // ecall/ebreak and csr ops
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_OP     = 7'b0110011; // r-type alu

  // upstream fetch word, already uncompressed
  typedef struct packed {
    logic   valid;
    addr_t  addr;
    instr_t instr;
  } fetch_in_t;

  // decoded view of one instruction
  typedef struct packed {
    logic     changes_pc; // jal, jalr, branch, fence, ecall/ebreak
    logic     has_rd;
    logic     has_rs1;
    logic     has_rs2;
    log_reg_t rd;
    log_reg_t rs1;
    log_reg_t rs2;
  } instr_info_t;

  // physical indices, zero where a field is unused
  typedef struct packed {
    phys_reg_t rd_phys;
    phys_reg_t rs1_phys;
    phys_reg_t rs2_phys;
  } renamed_t;

  // word handed to the id/ex stage
  typedef struct packed {
    addr_t    addr;
    instr_t   instr;
    renamed_t renamed;
  } fetch_out_t;

endpackage

/* source/instr_classifier.sv */
`timescale 1ns/1ps

module instr_classifier (
  input  shuffle_pkg::instr_t      instr_i,
  output shuffle_pkg::instr_info_t info_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       is_system;
  logic       is_env;     // ecall / ebreak, funct3 == 0
  logic       is_csr_imm; // csrrwi, csrrsi, csrrci

  assign opcode    = instr_i[6:0];
  assign funct3    = instr_i[14:12];
  assign is_system = (opcode == shuffle_pkg::OPC_SYSTEM);
  assign is_env    = is_system && (funct3 == 3'b000);
  // imm forms put a zimm in the rs1 slot
  assign is_csr_imm = is_system && ((funct3 == 3'b101) || (funct3 == 3'b110) ||
                                    (funct3 == 3'b111));

  always_comb begin
    // anything that may redirect the pc stops acceptance behind it
    info_o.changes_pc = (opcode == shuffle_pkg::OPC_JAL)    ||
                        (opcode == shuffle_pkg::OPC_JALR)   ||
                        (opcode == shuffle_pkg::OPC_BRANCH) ||
                        (opcode == shuffle_pkg::OPC_FENCE)  ||
                        is_env;

    // b/s-type, fence and env calls write nothing
    info_o.has_rd = (opcode != shuffle_pkg::OPC_BRANCH) &&
                    (opcode != shuffle_pkg::OPC_STORE)  &&
                    (opcode != shuffle_pkg::OPC_FENCE)  &&
                    !is_env;

    info_o.has_rs1 = (opcode != shuffle_pkg::OPC_LUI)   && // u-type
                     (opcode != shuffle_pkg::OPC_AUIPC) &&
                     (opcode != shuffle_pkg::OPC_JAL)   && // j-type
                     (opcode != shuffle_pkg::OPC_FENCE) &&
                     !is_env && !is_csr_imm;

    // only b, s and r types read a second source
    info_o.has_rs2 = (opcode == shuffle_pkg::OPC_BRANCH) ||
                     (opcode == shuffle_pkg::OPC_STORE)  ||
                     (opcode == shuffle_pkg::OPC_OP);

    // fixed field positions for every format
    info_o.rd  = instr_i[11:7];
    info_o.rs1 = instr_i[19:15];
    info_o.rs2 = instr_i[24:20];
  end

endmodule

/* source/branch_hold_ctrl.sv */
`timescale 1ns/1ps

module branch_hold_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                branch_i,     // id/ex redirect, one cycle
  input  logic                push_i,       // instruction accepted this cycle
  input  logic                changes_pc_i, // ... and it may change the pc
  input  shuffle_pkg::addr_t  push_addr_i,
  input  logic                pop_i,        // head handed to id/ex
  input  shuffle_pkg::addr_t  head_addr_i,
  input  logic                out_ready_i,
  output logic                discard_o,
  output logic                fetch_hold_o
);

  logic               discard_d, discard_q;
  shuffle_pkg::addr_t branch_addr_d, branch_addr_q; // pc of the branch being held
  logic               just_out_d, just_out_q;       // held branch left last cycle
  logic               not_taken;

  // id/ex keeps ready high after a branch that did not redirect
  assign not_taken = just_out_q && out_ready_i;

  always_comb begin
    discard_d     = discard_q;
    branch_addr_d = branch_addr_q;
    just_out_d    = pop_i && discard_q && (head_addr_i == branch_addr_q);

    if (branch_i || not_taken) begin
      discard_d = 1'b0; // outcome known, resume
    end
    // a new pc-changing instruction wins over a release in the same cycle
    if (push_i && changes_pc_i) begin
      discard_d     = 1'b1;
      branch_addr_d = push_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      discard_q  <= 1'b0;
      just_out_q <= 1'b0;
    end else begin
      discard_q  <= discard_d;
      just_out_q <= just_out_d;
    end
  end

  always_ff @(posedge clk_i) begin
    branch_addr_q <= branch_addr_d;
  end

  assign discard_o    = discard_q;
  assign fetch_hold_o = discard_q && !not_taken; // release early on not-taken
endmodule

/* source/shuffle_buffer.sv */
`timescale 1ns/1ps

module shuffle_buffer #(
  parameter  int unsigned DEPTH = 5,
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  shuffle_pkg::fetch_in_t  fetch_i,
  input  logic                    branch_i,
  input  logic                    fetch_hold_i,   // a pc-changing instruction is unresolved
  input  logic                    discard_i,
  input  shuffle_pkg::renamed_t   head_renamed_i, // from the rename table
  input  logic                    out_ready_i,
  output logic                    fetch_ready_o,
  output logic                    out_valid_o,
  output shuffle_pkg::fetch_out_t out_o,
  output logic                    push_o,
  output logic                    pop_o,
  output logic [PTR_W-1:0]        head_ptr_o,
  output logic [PTR_W-1:0]        tail_ptr_o
);

  shuffle_pkg::addr_t  addr_q  [DEPTH]; // pc per slot
  shuffle_pkg::instr_t instr_q [DEPTH];

  logic [DEPTH-1:0] valid_d, valid_q;
  logic [PTR_W-1:0] head_d, head_q; // oldest entry
  logic [PTR_W-1:0] tail_d, tail_q; // next free slot
  logic             full, not_empty;

  assign full      = &valid_q;
  assign not_empty = |valid_q;

  // while a branch is pending the partial contents drain, otherwise wait until full
  assign out_valid_o = full || (not_empty && discard_i);
  assign pop_o       = out_valid_o && out_ready_i;

  // a full buffer still takes a word when the head leaves in the same cycle
  assign fetch_ready_o = !branch_i && (!full || pop_o) && !fetch_hold_i;
  assign push_o        = fetch_ready_o && fetch_i.valid;

  always_comb begin
    valid_d = valid_q;
    head_d  = head_q;
    tail_d  = tail_q;

    // pop before push, head and tail may name the same slot
    if (pop_o) begin
      valid_d[head_q] = 1'b0;
      head_d = (head_q == PTR_W'(DEPTH - 1)) ? '0 : head_q + 1'b1; // wrap at DEPTH
    end
    if (push_o) begin
      valid_d[tail_q] = 1'b1;
      tail_d = (tail_q == PTR_W'(DEPTH - 1)) ? '0 : tail_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      head_q  <= '0;
      tail_q  <= '0;
    end else begin
      valid_q <= valid_d;
      head_q  <= head_d;
      tail_q  <= tail_d;
    end
  end

  // payload write, the slot only becomes visible through valid_q
  always_ff @(posedge clk_i) begin
    if (push_o) begin
      addr_q[tail_q]  <= fetch_i.addr;
      instr_q[tail_q] <= fetch_i.instr;
    end
  end

  assign out_o.addr    = addr_q[head_q];
  assign out_o.instr   = instr_q[head_q];
  assign out_o.renamed = head_renamed_i;

  assign head_ptr_o = head_q;
  assign tail_ptr_o = tail_q;

endmodule

/* source/rename_table.sv */
`timescale 1ns/1ps

module rename_table #(
  parameter  int unsigned DEPTH = 5,
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     push_i,
  input  logic                     pop_i,
  input  shuffle_pkg::instr_info_t info_i,    // decode of the incoming word
  input  logic [PTR_W-1:0]         head_ptr_i,
  input  logic [PTR_W-1:0]         tail_ptr_i, // slot written on push
  output shuffle_pkg::renamed_t    head_renamed_o
);

  localparam int unsigned NLOG  = shuffle_pkg::NUM_LOG_REGS;
  localparam int unsigned NPHYS = shuffle_pkg::NUM_PHYS_REGS;

  shuffle_pkg::phys_reg_t map_d   [NLOG]; // logical -> physical
  shuffle_pkg::phys_reg_t map_q   [NLOG];
  shuffle_pkg::phys_vec_t rsv_d, rsv_q;   // same info as the map, as a bit vector
  shuffle_pkg::phys_vec_t usage_d [DEPTH]; // regs touched by each buffered entry
  shuffle_pkg::phys_vec_t usage_q [DEPTH];
  shuffle_pkg::renamed_t  ren_q   [DEPTH];

  shuffle_pkg::phys_vec_t in_use;
  shuffle_pkg::phys_reg_t free_idx;
  shuffle_pkg::renamed_t  new_ren;
  shuffle_pkg::phys_reg_t head_rd;

  // a reg that is not mapped any more may still be read by a buffered entry
  always_comb begin
    in_use = rsv_q;
    for (int i = 0; i < DEPTH; i++) begin
      in_use |= usage_q[i];
    end
    free_idx = '0; // no free reg left, falls back to 0
    for (int i = NPHYS - 1; i >= 0; i--) begin
      if (!in_use[i]) begin
        free_idx = shuffle_pkg::PHYS_IDX_W'(i); // lowest index wins
      end
    end
  end

  // sources read the map from before this cycle's update
  assign new_ren.rd_phys  = info_i.has_rd  ? free_idx           : '0;
  assign new_ren.rs1_phys = info_i.has_rs1 ? map_q[info_i.rs1] : '0;
  assign new_ren.rs2_phys = info_i.has_rs2 ? map_q[info_i.rs2] : '0;
  assign head_rd          = ren_q[head_ptr_i].rd_phys;

  always_comb begin
    map_d   = map_q;
    rsv_d   = rsv_q;
    usage_d = usage_q;

    // release on hand-off to id/ex, x0's home reg 0 stays reserved
    if (pop_i) begin
      if (head_rd != '0) begin
        rsv_d[head_rd] = 1'b0;
      end
      usage_d[head_ptr_i] = '0;
    end

    if (push_i) begin
      if (info_i.has_rd) begin
        rsv_d[map_q[info_i.rd]] = 1'b0; // old mapping gives up its reservation
        map_d[info_i.rd]        = free_idx;
        rsv_d[free_idx]         = 1'b1;
      end
      usage_d[tail_ptr_i] = (shuffle_pkg::phys_vec_t'(1) << new_ren.rd_phys)  |
                            (shuffle_pkg::phys_vec_t'(1) << new_ren.rs1_phys) |
                            (shuffle_pkg::phys_vec_t'(1) << new_ren.rs2_phys);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NLOG; i++) begin
        map_q[i] <= shuffle_pkg::PHYS_IDX_W'(i); // identity map
      end
      rsv_q   <= {{(NPHYS - NLOG){1'b0}}, {NLOG{1'b1}}}; // regs 0..31 held
      usage_q <= '{default: '0};
    end else begin
      map_q   <= map_d;
      rsv_q   <= rsv_d;
      usage_q <= usage_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      ren_q[tail_ptr_i] <= new_ren;
    end
  end

  assign head_renamed_o = ren_q[head_ptr_i];

endmodule

/* source/shuffle_fetch_top.sv */
`timescale 1ns/1ps

module shuffle_fetch_top #(
  parameter int unsigned DEPTH = 5 // buffer slots
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  shuffle_pkg::fetch_in_t  fetch_i,
  output logic                    fetch_ready_o,
  input  logic                    branch_i,     // redirect from id/ex
  input  logic                    out_ready_i,
  output logic                    out_valid_o,
  output shuffle_pkg::fetch_out_t out_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  shuffle_pkg::instr_info_t info;
  shuffle_pkg::renamed_t    head_renamed;
  logic                     discard, fetch_hold;
  logic                     push, pop;
  logic [PTR_W-1:0]         head_ptr, tail_ptr;

  instr_classifier u_classifier (
    .instr_i (fetch_i.instr),
    .info_o  (info)
  );

  // watches accepted pc-changers and the head leaving
  branch_hold_ctrl u_hold (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .branch_i     (branch_i),
    .push_i       (push),
    .changes_pc_i (info.changes_pc),
    .push_addr_i  (fetch_i.addr),
    .pop_i        (pop),
    .head_addr_i  (out_o.addr),
    .out_ready_i  (out_ready_i),
    .discard_o    (discard),
    .fetch_hold_o (fetch_hold)
  );

  shuffle_buffer #(.DEPTH(DEPTH)) u_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_i        (fetch_i),
    .branch_i       (branch_i),
    .fetch_hold_i   (fetch_hold),
    .discard_i      (discard),
    .head_renamed_i (head_renamed),
    .out_ready_i    (out_ready_i),
    .fetch_ready_o  (fetch_ready_o),
    .out_valid_o    (out_valid_o),
    .out_o          (out_o),
    .push_o         (push),
    .pop_o          (pop),
    .head_ptr_o     (head_ptr),
    .tail_ptr_o     (tail_ptr)
  );

  rename_table #(.DEPTH(DEPTH)) u_rename (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .pop_i          (pop),
    .info_i         (info),
    .head_ptr_i     (head_ptr),
    .tail_ptr_i     (tail_ptr),
    .head_renamed_o (head_renamed)
  );

endmodule

/* testbench/shuffle_fetch_tb.sv */
`timescale 1ns/1ps

module shuffle_fetch_tb;

  localparam int unsigned DEPTH       = 5;
  localparam int unsigned N_TXN       = 400;         // transfers to id/ex before the run ends
  localparam int unsigned TIMEOUT_CYC = N_TXN * 40;  // watchdog budget in cycles

  typedef logic [127:0] wide_t; // common width for compares

  // one buffered instruction as the model sees it
  typedef struct packed {
    shuffle_pkg::fetch_out_t out;
    shuffle_pkg::phys_vec_t  usage; // rd, rs1 and rs2 physical regs of this entry
  } entry_t;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  shuffle_pkg::fetch_in_t  fetch_i;
  logic                    fetch_ready_o;
  logic                    branch_i;
  logic                    out_ready_i;
  logic                    out_valid_o;
  shuffle_pkg::fetch_out_t out_o;

  integer                   seed = 78;
  shuffle_pkg::instr_info_t cur_info;                // classes of the word on fetch_i
  shuffle_pkg::addr_t       next_pc = 32'h0000_1000; // unique pc per generated word
  entry_t                   q_exp[$];                // accepted but not yet transferred
  shuffle_pkg::phys_reg_t   m_map [shuffle_pkg::NUM_LOG_REGS];
  shuffle_pkg::phys_vec_t   m_rsv;
  logic                     m_discard  = 1'b0;
  logic                     m_just_out = 1'b0;       // held branch left last cycle
  logic                     m_pushed   = 1'b0;
  logic                     m_stalled  = 1'b0;       // head was valid but not taken
  logic                     seen_rd    = 1'b0;       // first writer after reset accepted
  shuffle_pkg::addr_t       m_branch_addr = '0;
  shuffle_pkg::addr_t       first_rd_addr = '0;
  int unsigned              n_out = 0;

  shuffle_fetch_top #(.DEPTH(DEPTH)) DUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fetch_i       (fetch_i),
    .fetch_ready_o (fetch_ready_o),
    .branch_i      (branch_i),
    .out_ready_i   (out_ready_i),
    .out_valid_o   (out_valid_o),
    .out_o         (out_o)
  );

  always #4 clk_i = ~clk_i; // 8 ns period

  task automatic check_val(input string name, input wide_t exp_v, input wide_t act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] %s expected %0h actual %0h", name, exp_v, act_v);
      $display("Test FAILED");
      $fatal(1, "check %s mismatched", name);
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  // weighted opcode mix where about 15% may change the pc
  task automatic make_instr(output shuffle_pkg::instr_t w, output shuffle_pkg::instr_info_t inf);
    int unsigned pick;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [3:0]  flags; // changes_pc, has_rd, has_rs1, has_rs2
    w    = $random(seed);
    pick = rand_below(100);
    f3   = w[14:12];
    if (pick < 7) begin
      opc   = shuffle_pkg::OPC_BRANCH;
      flags = 4'b1011;
    end else if (pick < 10) begin
      opc   = shuffle_pkg::OPC_JAL;
      flags = 4'b1100;
    end else if (pick < 12) begin
      opc   = shuffle_pkg::OPC_JALR;
      flags = 4'b1110;
    end else if (pick < 13) begin
      opc   = shuffle_pkg::OPC_FENCE;
      flags = 4'b1000;
    end else if (pick < 15) begin
      opc   = shuffle_pkg::OPC_SYSTEM;
      flags = 4'b1000;
      f3    = 3'b000; // ecall/ebreak
    end else if (pick < 35) begin
      opc   = shuffle_pkg::OPC_OP;
      flags = 4'b0111;
    end else if (pick < 50) begin
      opc   = shuffle_pkg::OPC_LOAD;
      flags = 4'b0110;
    end else if (pick < 60) begin
      opc   = shuffle_pkg::OPC_STORE;
      flags = 4'b0011;
    end else if (pick < 65) begin
      opc   = shuffle_pkg::OPC_LUI;
      flags = 4'b0100;
    end else if (pick < 70) begin
      opc   = shuffle_pkg::OPC_AUIPC;
      flags = 4'b0100;
    end else if (pick < 78) begin
      opc   = shuffle_pkg::OPC_SYSTEM;
      flags = 4'b0100; // csr immediate with zimm in the rs1 slot
      f3    = 3'd5 + 3'(rand_below(3));
    end else if (pick < 84) begin
      opc   = shuffle_pkg::OPC_SYSTEM;
      flags = 4'b0110; // csr register form
      f3    = 3'd1 + 3'(rand_below(3));
    end else begin
      opc   = 7'b0010011;
      flags = 4'b0110; // op-imm
    end
    w[6:0]         = opc;
    w[14:12]       = f3;
    inf.changes_pc = flags[3];
    inf.has_rd     = flags[2];
    inf.has_rs1    = flags[1];
    inf.has_rs2    = flags[0];
    inf.rd         = w[11:7];
    inf.rs1        = w[19:15];
    inf.rs2        = w[24:20];
  endtask

  // a word not taken stays on the bus until accepted
  always @(posedge clk_i) begin
    shuffle_pkg::instr_t      w;
    shuffle_pkg::instr_info_t inf;
    shuffle_pkg::fetch_in_t   nf;
    if (rst_ni) begin
      if (!fetch_i.valid || m_pushed) begin
        make_instr(w, inf);
        nf.valid = (rand_below(10) < 8);
        nf.addr  = next_pc;
        nf.instr = w;
        next_pc  = next_pc + 32'd4;
        fetch_i  <= nf;
        cur_info <= inf;
      end
      out_ready_i <= (rand_below(10) < 7);
      branch_i    <= m_discard && !branch_i && (rand_below(6) == 0); // one-cycle redirect
    end
  end

  // model and checks sampled mid cycle
  always @(negedge clk_i) begin
    logic                   full, exp_valid, pop, push, not_taken, exp_ready, nxt_just;
    shuffle_pkg::phys_vec_t in_use;
    shuffle_pkg::phys_reg_t free_idx;
    entry_t                 e;
    if (rst_ni) begin
      full      = (q_exp.size() == DEPTH);
      exp_valid = full || ((q_exp.size() != 0) && m_discard);
      check_val("out_valid", wide_t'(exp_valid), wide_t'(out_valid_o));
      if (exp_valid && m_stalled) begin
        check_val("stall_head_addr", wide_t'(q_exp[0].out.addr), wide_t'(out_o.addr));
      end
      pop       = exp_valid && out_ready_i;
      not_taken = m_just_out && out_ready_i; // id/ex let the held branch go by
      exp_ready = !branch_i && (!full || pop) && !(m_discard && !not_taken);
      check_val("fetch_ready", wide_t'(exp_ready), wide_t'(fetch_ready_o));
      push = exp_ready && fetch_i.valid;

      // lowest reg that nothing reserves or buffers before this edge
      in_use = m_rsv;
      foreach (q_exp[i]) begin
        in_use |= q_exp[i].usage;
      end
      free_idx = '0;
      for (int i = shuffle_pkg::NUM_PHYS_REGS - 1; i >= 0; i--) begin
        if (!in_use[i]) free_idx = shuffle_pkg::phys_reg_t'(i);
      end

      nxt_just = 1'b0;
      if (pop) begin
        check_val("order_addr", wide_t'(q_exp[0].out.addr), wide_t'(out_o.addr));
        check_val("order_instr", wide_t'(q_exp[0].out.instr), wide_t'(out_o.instr));
        check_val("rename", wide_t'(q_exp[0].out.renamed), wide_t'(out_o.renamed));
        if (seen_rd && (q_exp[0].out.addr == first_rd_addr)) begin
          check_val("first_rd_after_reset", wide_t'(32), wide_t'(out_o.renamed.rd_phys));
        end
        if (q_exp[0].out.renamed.rd_phys != '0) begin
          m_rsv[q_exp[0].out.renamed.rd_phys] = 1'b0;
        end
        nxt_just = m_discard && (q_exp[0].out.addr == m_branch_addr);
        e = q_exp.pop_front();
        n_out++;
      end

      if (push) begin
        e.out.addr             = fetch_i.addr;
        e.out.instr            = fetch_i.instr;
        e.out.renamed.rd_phys  = cur_info.has_rd ? free_idx : '0;
        e.out.renamed.rs1_phys = cur_info.has_rs1 ? m_map[cur_info.rs1] : '0; // old map
        e.out.renamed.rs2_phys = cur_info.has_rs2 ? m_map[cur_info.rs2] : '0;
        e.usage = (shuffle_pkg::phys_vec_t'(1) << e.out.renamed.rd_phys) |
                  (shuffle_pkg::phys_vec_t'(1) << e.out.renamed.rs1_phys) |
                  (shuffle_pkg::phys_vec_t'(1) << e.out.renamed.rs2_phys);
        if (cur_info.has_rd) begin
          if (!seen_rd) begin
            first_rd_addr = fetch_i.addr; // its rd must land on the first free reg
          end
          seen_rd                   = 1'b1;
          m_rsv[m_map[cur_info.rd]] = 1'b0;
          m_map[cur_info.rd]        = free_idx;
          m_rsv[free_idx]           = 1'b1;
        end
        q_exp.push_back(e);
      end

      if (branch_i || not_taken) m_discard = 1'b0;
      if (push && cur_info.changes_pc) begin // a new hold wins over a release
        m_discard     = 1'b1;
        m_branch_addr = fetch_i.addr;
      end
      m_just_out = nxt_just;
      m_pushed   = push;
      m_stalled  = exp_valid && !out_ready_i;
    end
  end

  initial begin
    fetch_i     = '0;
    branch_i    = 1'b0;
    out_ready_i = 1'b0;
    cur_info    = '0;
    rst_ni      = 1'b0;
    for (int i = 0; i < shuffle_pkg::NUM_PHYS_REGS; i++) begin
      m_rsv[i] = (i < shuffle_pkg::NUM_LOG_REGS); // x0..x31 homes held
    end
    for (int i = 0; i < shuffle_pkg::NUM_LOG_REGS; i++) begin
      m_map[i] = shuffle_pkg::phys_reg_t'(i);
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_val("reset_out_valid", wide_t'(1'b0), wide_t'(out_valid_o));
    @(posedge clk_i);
    rst_ni <= 1'b1; // released after 3 cycles
    wait (n_out >= N_TXN);
    @(posedge clk_i);
    $display("Test OK");
    $finish;
  end

  // watchdog
  initial begin
    repeat (TIMEOUT_CYC) @(posedge clk_i);
    $display("watchdog expired after %0d cycles with %0d of %0d transfers done",
             TIMEOUT_CYC, n_out, N_TXN);
    $display("Test FAILED");
    $fatal(1, "simulation timed out");
  end

endmodule

/* all.f */
source/shuffle_pkg.sv
source/instr_classifier.sv
source/branch_hold_ctrl.sv
source/shuffle_buffer.sv
source/rename_table.sv
source/shuffle_fetch_top.sv
testbench/shuffle_fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, then scan the log for failure
rm -rf obj_dir sim.log build.log
verilator --binary --timing --top-module shuffle_fetch_tb -f all.f > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vshuffle_fetch_tb > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation finished without failure"; exit 0; }
